//--- src/noc_macros.svh
// router-wide widths, flit field positions, type codes and port indices, included by pkg and RTL
`ifndef NOC_MACROS_SVH
`define NOC_MACROS_SVH

`define NOC_FLIT_W       32
`define NOC_NUM_PORTS    5
`define NOC_FIFO_DEPTH   4

`define NOC_TYPE_HI      31  // flit kind field
`define NOC_TYPE_LO      30
`define NOC_DX_HI        23  // destination x
`define NOC_DX_LO        22
`define NOC_DY_HI        21  // destination y
`define NOC_DY_LO        20

`define NOC_TYPE_INVALID 2'b00
`define NOC_TYPE_HEAD    2'b01
`define NOC_TYPE_BODY    2'b10
`define NOC_TYPE_TAIL    2'b11

`define NOC_PORT_NORTH   3'd0
`define NOC_PORT_SOUTH   3'd1
`define NOC_PORT_EAST    3'd2
`define NOC_PORT_WEST    3'd3
`define NOC_PORT_LOCAL   3'd4

`endif

//--- src/noc_pkg.sv
// shared router types, referenced by scoped name from the RTL and the testbench
`include "noc_macros.svh"

package noc_pkg;

	typedef logic [`NOC_FLIT_W-1:0]    flit_t;
	typedef logic [1:0]                flit_kind_t;  // head, body, tail or invalid
	typedef logic [1:0]                coord_t;      // one mesh axis
	typedef logic [2:0]                port_id_t;    // north..local
	typedef logic [`NOC_NUM_PORTS-1:0] port_mask_t;
	typedef logic [2:0]                count_t;      // 0 to 4 flits held

	// what an input buffer shows the arbiters about its oldest flit
	typedef struct packed {
		logic       valid;  // buffer not empty
		flit_kind_t kind;
		port_id_t   route;  // XY output, only for heads
		flit_t      front;
	} in_status_t;

	// one output port's decision for this cycle
	typedef struct packed {
		logic     send;  // flit transferred at next edge
		port_id_t src;   // locked input
	} out_grant_t;

	typedef enum logic {
		arb_idle,
		arb_busy
	} arb_state_t;

endpackage

//--- src/input_buffer.sv
// four-entry flit FIFO for one router input, also resolves the XY output of its front flit
`timescale 1ns/1ps
`include "noc_macros.svh"

module input_buffer (
	input  logic                clk,
	input  logic                reset,
	input  noc_pkg::flit_t      push_flit,
	input  logic                push,
	input  logic                pop,
	input  noc_pkg::coord_t     router_x,
	input  noc_pkg::coord_t     router_y,
	output noc_pkg::count_t     count,
	output noc_pkg::in_status_t status
);
	localparam int PTR_W = $clog2(`NOC_FIFO_DEPTH);

	noc_pkg::flit_t      mem [`NOC_FIFO_DEPTH];
	logic [PTR_W-1:0]    rd_ptr;
	logic [PTR_W-1:0]    wr_ptr;
	noc_pkg::count_t     occ;
	noc_pkg::flit_kind_t push_kind;
	noc_pkg::flit_t      front;
	noc_pkg::coord_t     dest_x;
	noc_pkg::coord_t     dest_y;
	noc_pkg::port_id_t   route;
	logic                empty;
	logic                full;
	logic                do_push;
	logic                do_pop;

	assign push_kind = push_flit[`NOC_TYPE_HI:`NOC_TYPE_LO];
	assign empty     = (occ == '0);
	assign full      = (occ == noc_pkg::count_t'(`NOC_FIFO_DEPTH));
	assign do_pop    = pop && !empty;
	// a full buffer still takes a flit when the front leaves in the same cycle
	assign do_push   = push && (push_kind != `NOC_TYPE_INVALID) && (!full || do_pop);

	always_ff @(posedge clk) begin
		if (do_push) begin
			mem[wr_ptr] <= push_flit;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			occ    <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= wr_ptr + 1'b1;  // wraps at depth
			end
			if (do_pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({do_push, do_pop})
				2'b10:   occ <= occ + 1'b1;
				2'b01:   occ <= occ - 1'b1;
				default: occ <= occ;  // idle or push and pop together
			endcase
		end
	end

	assign front  = mem[rd_ptr];
	assign dest_x = front[`NOC_DX_HI:`NOC_DX_LO];
	assign dest_y = front[`NOC_DY_HI:`NOC_DY_LO];

	// dimension order, x first then y
	always_comb begin
		if (dest_x > router_x) begin
			route = `NOC_PORT_EAST;
		end else if (dest_x < router_x) begin
			route = `NOC_PORT_WEST;
		end else if (dest_y > router_y) begin
			route = `NOC_PORT_NORTH;
		end else if (dest_y < router_y) begin
			route = `NOC_PORT_SOUTH;
		end else begin
			route = `NOC_PORT_LOCAL;
		end
	end

	assign status.valid = !empty;
	assign status.kind  = front[`NOC_TYPE_HI:`NOC_TYPE_LO];
	assign status.route = route;
	assign status.front = front;
	assign count        = occ;

endmodule

//--- src/output_arbiter.sv
// round-robin wormhole allocator for one output port, holds the port from head to tail
`timescale 1ns/1ps
`include "noc_macros.svh"

module output_arbiter #(
	parameter noc_pkg::port_id_t MY_PORT = '0
) (
	input  logic                                    clk,
	input  logic                                    reset,
	input  noc_pkg::in_status_t [`NOC_NUM_PORTS-1:0] status,
	input  logic                                    full,
	output noc_pkg::out_grant_t                     grant
);
	localparam noc_pkg::port_id_t LAST_PORT = noc_pkg::port_id_t'(`NOC_NUM_PORTS - 1);

	noc_pkg::arb_state_t state;
	noc_pkg::port_id_t   src_q;   // input owning this output
	noc_pkg::port_id_t   rr_ptr;  // first input looked at when idle
	noc_pkg::port_id_t   pick;
	noc_pkg::port_mask_t req;
	noc_pkg::in_status_t cur;
	logic                found;
	logic                send;
	logic                tail_sent;

	// heads waiting at a buffer front that want this port
	always_comb begin
		for (int i = 0; i < `NOC_NUM_PORTS; i++) begin
			req[i] = status[i].valid && (status[i].kind == `NOC_TYPE_HEAD) &&
				(status[i].route == MY_PORT);
		end
	end

	// first requester at or after rr_ptr, wrapping round
	always_comb begin
		int idx;
		found = 1'b0;
		pick  = rr_ptr;
		for (int i = 0; i < `NOC_NUM_PORTS; i++) begin
			idx = (int'(rr_ptr) + i) % `NOC_NUM_PORTS;
			if (!found && req[idx]) begin
				found = 1'b1;
				pick  = noc_pkg::port_id_t'(idx);
			end
		end
	end

	assign cur       = status[src_q];
	assign send      = (state == noc_pkg::arb_busy) && cur.valid && !full;
	assign tail_sent = send && (cur.kind == `NOC_TYPE_TAIL);

	always_ff @(posedge clk) begin
		if (reset) begin
			state  <= noc_pkg::arb_idle;
			src_q  <= '0;
			rr_ptr <= `NOC_PORT_NORTH;
		end else begin
			case (state)
				noc_pkg::arb_idle: begin
					if (found) begin  // lock now, first flit moves next cycle
						state  <= noc_pkg::arb_busy;
						src_q  <= pick;
						rr_ptr <= (pick == LAST_PORT) ? '0 : pick + 1'b1;
					end
				end
				noc_pkg::arb_busy: begin
					if (tail_sent) begin
						state <= noc_pkg::arb_idle;  // packet done, release port
					end
				end
				default: state <= noc_pkg::arb_idle;
			endcase
		end
	end

	assign grant.send = send;
	assign grant.src  = src_q;

endmodule

//--- src/crossbar.sv
// steers each output's granted front flit out and sends pop strobes back to the inputs
`timescale 1ns/1ps
`include "noc_macros.svh"

module crossbar (
	input  noc_pkg::in_status_t [`NOC_NUM_PORTS-1:0] status,
	input  noc_pkg::out_grant_t [`NOC_NUM_PORTS-1:0] grant,
	output noc_pkg::flit_t      [`NOC_NUM_PORTS-1:0] out_flit,
	output noc_pkg::port_mask_t                      out_valid,
	output noc_pkg::port_mask_t                      pop
);

	// output side mux, data follows the lock even when nothing moves
	always_comb begin
		for (int o = 0; o < `NOC_NUM_PORTS; o++) begin
			out_flit[o]  = status[grant[o].src].front;
			out_valid[o] = grant[o].send;
		end
	end

	// input side, at most one output ever sends from a given input
	always_comb begin
		pop = '0;
		for (int i = 0; i < `NOC_NUM_PORTS; i++) begin
			for (int o = 0; o < `NOC_NUM_PORTS; o++) begin
				if (grant[o].send && (grant[o].src == noc_pkg::port_id_t'(i))) begin
					pop[i] = 1'b1;
				end
			end
		end
	end

endmodule

//--- src/mesh_router.sv
// five-port XY mesh router top, buffers feed per-output arbiters through one crossbar
`timescale 1ns/1ps
`include "noc_macros.svh"

module mesh_router (
	input  logic                                 clk,
	input  logic                                 reset,
	input  noc_pkg::coord_t                      router_x,
	input  noc_pkg::coord_t                      router_y,
	input  noc_pkg::flit_t  [`NOC_NUM_PORTS-1:0] in_flit,
	input  noc_pkg::port_mask_t                  in_push,   // one strobe per flit
	output noc_pkg::count_t [`NOC_NUM_PORTS-1:0] in_count,
	output noc_pkg::flit_t  [`NOC_NUM_PORTS-1:0] out_flit,
	output noc_pkg::port_mask_t                  out_valid,
	input  noc_pkg::port_mask_t                  out_full   // downstream back-pressure
);
	noc_pkg::in_status_t [`NOC_NUM_PORTS-1:0] in_status;
	noc_pkg::out_grant_t [`NOC_NUM_PORTS-1:0] out_grant;
	noc_pkg::port_mask_t                      in_pop;

	for (genvar g = 0; g < `NOC_NUM_PORTS; g++) begin : g_in
		input_buffer u_in_buf (
			.clk       (clk),
			.reset     (reset),
			.push_flit (in_flit[g]),
			.push      (in_push[g]),
			.pop       (in_pop[g]),
			.router_x  (router_x),
			.router_y  (router_y),
			.count     (in_count[g]),
			.status    (in_status[g])
		);
	end

	// one peer arbiter per output, all watching every buffer front
	for (genvar g = 0; g < `NOC_NUM_PORTS; g++) begin : g_out
		output_arbiter #(
			.MY_PORT (noc_pkg::port_id_t'(g))
		) u_out_arb (
			.clk    (clk),
			.reset  (reset),
			.status (in_status),
			.full   (out_full[g]),
			.grant  (out_grant[g])
		);
	end

	crossbar u_crossbar (
		.status    (in_status),
		.grant     (out_grant),
		.out_flit  (out_flit),
		.out_valid (out_valid),
		.pop       (in_pop)
	);

endmodule

//--- test/packet_table.svh
// packet rows pushed by the router testbench, included inside the testbench module
`ifndef PACKET_TABLE_SVH
`define PACKET_TABLE_SVH

// columns: source port, dest x, dest y, packet flits, invalid flit slot (0 none),
// overflow flits pushed while out_full is held (0 none), phase (same phase pushed together)
typedef struct packed {
	noc_pkg::port_id_t src;
	noc_pkg::coord_t   dx;
	noc_pkg::coord_t   dy;
	logic [3:0]        len;
	logic [3:0]        inv_at;
	logic [3:0]        extra;
	logic [7:0]        phase;
} pkt_row_t;

localparam int NUM_ROWS = 42;

localparam pkt_row_t PKT_TABLE [NUM_ROWS] = '{
	'{`NOC_PORT_NORTH, 2'd1, 2'd3, 4'd2, 4'd0, 4'd0, 8'd1},  // one packet at a time
	'{`NOC_PORT_NORTH, 2'd1, 2'd0, 4'd3, 4'd0, 4'd0, 8'd2},
	'{`NOC_PORT_NORTH, 2'd3, 2'd1, 4'd4, 4'd0, 4'd0, 8'd3},
	'{`NOC_PORT_NORTH, 2'd0, 2'd2, 4'd5, 4'd0, 4'd0, 8'd4},
	'{`NOC_PORT_NORTH, 2'd1, 2'd1, 4'd2, 4'd0, 4'd0, 8'd5},
	'{`NOC_PORT_SOUTH, 2'd1, 2'd2, 4'd3, 4'd0, 4'd0, 8'd6},
	'{`NOC_PORT_SOUTH, 2'd1, 2'd0, 4'd4, 4'd0, 4'd0, 8'd7},
	'{`NOC_PORT_SOUTH, 2'd2, 2'd0, 4'd5, 4'd0, 4'd0, 8'd8},
	'{`NOC_PORT_SOUTH, 2'd0, 2'd0, 4'd2, 4'd0, 4'd0, 8'd9},
	'{`NOC_PORT_SOUTH, 2'd1, 2'd1, 4'd3, 4'd0, 4'd0, 8'd10},
	'{`NOC_PORT_EAST,  2'd1, 2'd3, 4'd4, 4'd0, 4'd0, 8'd11},
	'{`NOC_PORT_EAST,  2'd1, 2'd0, 4'd5, 4'd0, 4'd0, 8'd12},
	'{`NOC_PORT_EAST,  2'd2, 2'd3, 4'd2, 4'd0, 4'd0, 8'd13},
	'{`NOC_PORT_EAST,  2'd0, 2'd1, 4'd3, 4'd0, 4'd0, 8'd14},
	'{`NOC_PORT_EAST,  2'd1, 2'd1, 4'd4, 4'd0, 4'd0, 8'd15},
	'{`NOC_PORT_WEST,  2'd1, 2'd2, 4'd5, 4'd0, 4'd0, 8'd16},
	'{`NOC_PORT_WEST,  2'd1, 2'd0, 4'd2, 4'd0, 4'd0, 8'd17},
	'{`NOC_PORT_WEST,  2'd3, 2'd3, 4'd3, 4'd0, 4'd0, 8'd18},
	'{`NOC_PORT_WEST,  2'd0, 2'd3, 4'd4, 4'd0, 4'd0, 8'd19},
	'{`NOC_PORT_WEST,  2'd1, 2'd1, 4'd5, 4'd0, 4'd0, 8'd20},
	'{`NOC_PORT_LOCAL, 2'd1, 2'd3, 4'd2, 4'd0, 4'd0, 8'd21},
	'{`NOC_PORT_LOCAL, 2'd1, 2'd0, 4'd3, 4'd0, 4'd0, 8'd22},
	'{`NOC_PORT_LOCAL, 2'd2, 2'd1, 4'd4, 4'd0, 4'd0, 8'd23},
	'{`NOC_PORT_LOCAL, 2'd0, 2'd0, 4'd5, 4'd0, 4'd0, 8'd24},
	'{`NOC_PORT_LOCAL, 2'd1, 2'd1, 4'd6, 4'd0, 4'd0, 8'd25},
	'{`NOC_PORT_WEST,  2'd3, 2'd1, 4'd4, 4'd2, 4'd0, 8'd26},  // invalid flit mid packet
	'{`NOC_PORT_LOCAL, 2'd1, 2'd2, 4'd3, 4'd1, 4'd0, 8'd27},
	'{`NOC_PORT_NORTH, 2'd1, 2'd0, 4'd4, 4'd0, 4'd2, 8'd28},  // six pushes, two dropped
	'{`NOC_PORT_SOUTH, 2'd1, 2'd1, 4'd5, 4'd0, 4'd0, 8'd29},  // three inputs want local
	'{`NOC_PORT_EAST,  2'd1, 2'd1, 4'd5, 4'd0, 4'd0, 8'd29},
	'{`NOC_PORT_WEST,  2'd1, 2'd1, 4'd3, 4'd0, 4'd0, 8'd29},
	'{`NOC_PORT_NORTH, 2'd2, 2'd3, 4'd6, 4'd0, 4'd0, 8'd30},  // two inputs want east
	'{`NOC_PORT_LOCAL, 2'd3, 2'd0, 4'd6, 4'd0, 4'd0, 8'd30},
	'{`NOC_PORT_NORTH, 2'd1, 2'd0, 4'd4, 4'd0, 4'd0, 8'd31},  // every output busy at once
	'{`NOC_PORT_SOUTH, 2'd1, 2'd3, 4'd4, 4'd0, 4'd0, 8'd31},
	'{`NOC_PORT_EAST,  2'd0, 2'd1, 4'd4, 4'd0, 4'd0, 8'd31},
	'{`NOC_PORT_WEST,  2'd3, 2'd2, 4'd4, 4'd0, 4'd0, 8'd31},
	'{`NOC_PORT_LOCAL, 2'd1, 2'd1, 4'd4, 4'd0, 4'd0, 8'd31},
	'{`NOC_PORT_NORTH, 2'd2, 2'd2, 4'd3, 4'd0, 4'd0, 8'd32},  // back to back per input
	'{`NOC_PORT_NORTH, 2'd0, 2'd2, 4'd2, 4'd0, 4'd0, 8'd32},
	'{`NOC_PORT_EAST,  2'd1, 2'd1, 4'd4, 4'd0, 4'd0, 8'd32},
	'{`NOC_PORT_EAST,  2'd1, 2'd2, 4'd3, 4'd0, 4'd0, 8'd32}
};

`endif

//--- test/mesh_router_tb.sv
// self-checking testbench for the mesh router, pushes the packet table and scoreboards each output
`timescale 1ns/1ps
`include "noc_macros.svh"

module mesh_router_tb;
	localparam int              NP       = `NOC_NUM_PORTS;
	localparam noc_pkg::coord_t ROUTER_X = 2'd1;  // centre of the mesh
	localparam noc_pkg::coord_t ROUTER_Y = 2'd1;

	`include "packet_table.svh"

	logic                         clk = 1'b0;
	logic                         reset;
	noc_pkg::coord_t              router_x;
	noc_pkg::coord_t              router_y;
	noc_pkg::flit_t      [NP-1:0] in_flit;
	noc_pkg::port_mask_t          in_push;
	noc_pkg::count_t     [NP-1:0] in_count;
	noc_pkg::flit_t      [NP-1:0] out_flit;
	noc_pkg::port_mask_t          out_valid;
	noc_pkg::port_mask_t          out_full;

	noc_pkg::flit_t src_q [NP][$];  // flits still to push, per input
	noc_pkg::flit_t exp_q [NP][$];  // flits still owed, per output
	bit             open_pkt [NP];  // output is inside a packet
	int             open_idx [NP];  // slot of that packet's next flit
	logic [31:0]    rng_state = 32'd46195;
	int             cycle_count = 0;
	int             timeout_limit;

	mesh_router u_mesh_router (
		.clk       (clk),
		.reset     (reset),
		.router_x  (router_x),
		.router_y  (router_y),
		.in_flit   (in_flit),
		.in_push   (in_push),
		.in_count  (in_count),
		.out_flit  (out_flit),
		.out_valid (out_valid),
		.out_full  (out_full)
	);

	always #2 clk = ~clk;

	task automatic stop_with_failure(input string why);
		$display("%s", why);
		$display("Some tests failed");
		$fatal(1, "stopping at the first error");
	endtask

	task automatic check_flit(input int port, input noc_pkg::flit_t got, input noc_pkg::flit_t exp);
		if (got !== exp)
			stop_with_failure($sformatf("ERR at %0t: output %0d flit %h, expected %h",
				$time, port, got, exp));
	endtask

	task automatic check_count(input int port, input noc_pkg::count_t got,
			input noc_pkg::count_t exp);
		if (got !== exp)
			stop_with_failure($sformatf("ERR at %0t: input %0d count %0d, expected %0d",
				$time, port, got, exp));
	endtask

	task automatic check_mask(input noc_pkg::port_mask_t got, input noc_pkg::port_mask_t exp);
		if (got !== exp)
			stop_with_failure($sformatf("ERR at %0t: out_valid %b, expected %b", $time, got, exp));
	endtask

	function automatic logic [31:0] next_random();
		rng_state ^= rng_state << 13;
		rng_state ^= rng_state >> 17;
		rng_state ^= rng_state << 5;
		return rng_state;
	endfunction

	function automatic noc_pkg::flit_t make_flit(input noc_pkg::flit_kind_t kind,
			input noc_pkg::coord_t dx, input noc_pkg::coord_t dy);
		noc_pkg::flit_t f;
		f = next_random();  // random payload around the fixed fields
		f[`NOC_TYPE_HI:`NOC_TYPE_LO] = kind;
		f[`NOC_DX_HI:`NOC_DX_LO]     = dx;
		f[`NOC_DY_HI:`NOC_DY_LO]     = dy;
		return f;
	endfunction

	function automatic noc_pkg::flit_kind_t kind_of(input int idx, input int len);
		if (idx == 0)
			return `NOC_TYPE_HEAD;
		else if (idx == len - 1)
			return `NOC_TYPE_TAIL;
		return `NOC_TYPE_BODY;
	endfunction

	// x first, then y, as a mesh router at ROUTER_X, ROUTER_Y resolves it
	function automatic noc_pkg::port_id_t route_of(input noc_pkg::coord_t dx,
			input noc_pkg::coord_t dy);
		if (dx > ROUTER_X)
			return `NOC_PORT_EAST;
		else if (dx < ROUTER_X)
			return `NOC_PORT_WEST;
		else if (dy > ROUTER_Y)
			return `NOC_PORT_NORTH;
		else if (dy < ROUTER_Y)
			return `NOC_PORT_SOUTH;
		return `NOC_PORT_LOCAL;
	endfunction

	function automatic int table_flits();
		int n;
		n = 0;
		for (int r = 0; r < NUM_ROWS; r++) begin
			n += int'(PKT_TABLE[r].len) + int'(PKT_TABLE[r].extra);
			n += (PKT_TABLE[r].inv_at != 0) ? 1 : 0;
		end
		return n;
	endfunction

	function automatic int expected_left();
		int n;
		n = 0;
		for (int p = 0; p < NP; p++)
			n += exp_q[p].size();
		return n;
	endfunction

	function automatic int pushes_left();
		int n;
		n = 0;
		for (int p = 0; p < NP; p++)
			n += src_q[p].size();
		return n;
	endfunction

	task automatic next_slot();
		@(posedge clk);
		#1;
	endtask

	// queue a row's pushes at its input and its owed flits at the XY output
	task automatic stage_row(input pkt_row_t row);
		noc_pkg::port_id_t port;
		noc_pkg::flit_t    f;
		port = route_of(row.dx, row.dy);
		for (int i = 0; i < int'(row.len); i++) begin
			if (row.inv_at != 0 && i == int'(row.inv_at))
				src_q[row.src].push_back(make_flit(`NOC_TYPE_INVALID, row.dx, row.dy));
			f = make_flit(kind_of(i, int'(row.len)), row.dx, row.dy);
			src_q[row.src].push_back(f);
			exp_q[port].push_back(f);
		end
		for (int i = 0; i < int'(row.extra); i++)  // overflow, never owed
			src_q[row.src].push_back(make_flit((i == 0) ? `NOC_TYPE_HEAD : `NOC_TYPE_BODY,
				row.dx, row.dy));
	endtask

	// all inputs in parallel, pushing only when the buffer has room
	task automatic push_staged();
		while (pushes_left() > 0) begin
			for (int p = 0; p < NP; p++) begin
				if (src_q[p].size() > 0 && in_count[p] < 3'd4) begin
					in_flit[p] = src_q[p].pop_front();
					in_push[p] = 1'b1;
				end else begin
					in_push[p] = 1'b0;
				end
			end
			next_slot();
		end
		in_push = '0;
	endtask

	// output held full, every flit pushed blindly, count checked after each push
	task automatic push_held(input pkt_row_t row);
		noc_pkg::port_id_t port;
		noc_pkg::flit_t    f;
		int                acc;
		port = route_of(row.dx, row.dy);
		acc  = 0;
		stage_row(row);
		out_full[port] = 1'b1;
		while (src_q[row.src].size() > 0) begin
			f = src_q[row.src].pop_front();
			in_flit[row.src] = f;
			in_push[row.src] = 1'b1;
			if (f[`NOC_TYPE_HI:`NOC_TYPE_LO] != `NOC_TYPE_INVALID)
				acc++;
			next_slot();
			in_push[row.src] = 1'b0;
			check_count(int'(row.src), in_count[row.src], noc_pkg::count_t'((acc > 4) ? 4 : acc));
		end
		repeat (8) next_slot();  // give a leak time to show
		check_count(int'(row.src), in_count[row.src], noc_pkg::count_t'((acc > 4) ? 4 : acc));
		out_full[port] = 1'b0;
	endtask

	task automatic wait_drained();
		while (expected_left() > 0)
			@(negedge clk);
		next_slot();  // last pop lands here
		for (int p = 0; p < NP; p++)
			check_count(p, in_count[p], '0);
	endtask

	// heads may win in any order, the rest of the packet must follow without a gap
	task automatic take_flit(input int o, input noc_pkg::flit_t got);
		int k;
		if (out_full[o]) begin
			stop_with_failure($sformatf("output %0d sent a flit while out_full was set", o));
		end else if (exp_q[o].size() == 0) begin
			stop_with_failure($sformatf("output %0d sent a flit when none was owed", o));
		end else begin
			k = open_pkt[o] ? open_idx[o] : 0;
			if (!open_pkt[o] && got[`NOC_TYPE_HI:`NOC_TYPE_LO] == `NOC_TYPE_HEAD) begin
				for (int j = 0; j < exp_q[o].size(); j++)
					if (exp_q[o][j] == got)
						k = j;
			end
			check_flit(o, got, exp_q[o][k]);
			exp_q[o].delete(k);
			open_idx[o] = k;
			open_pkt[o] = (got[`NOC_TYPE_HI:`NOC_TYPE_LO] != `NOC_TYPE_TAIL);
		end
	endtask

	always @(negedge clk) begin
		if (!reset) begin
			for (int o = 0; o < NP; o++)
				if (out_valid[o])
					take_flit(o, out_flit[o]);
		end
	end

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count > timeout_limit)
			stop_with_failure($sformatf("timeout, run still busy after %0d cycles", timeout_limit));
	end

	initial begin
		pkt_row_t row;
		int       r;
		reset    = 1'b1;
		router_x = ROUTER_X;
		router_y = ROUTER_Y;
		in_flit  = '0;
		in_push  = '0;
		out_full = '0;
		timeout_limit = 40 * table_flits() + 200;
		repeat (3) @(posedge clk);
		#1 reset = 1'b0;
		@(negedge clk);
		for (int p = 0; p < NP; p++)
			check_count(p, in_count[p], '0);
		check_mask(out_valid, '0);
		next_slot();
		r = 0;
		while (r < NUM_ROWS) begin
			row = PKT_TABLE[r];
			if (row.inv_at != 0 || row.extra != 0) begin
				push_held(row);
				r++;
			end else begin
				while (r < NUM_ROWS && PKT_TABLE[r].phase == row.phase) begin
					stage_row(PKT_TABLE[r]);
					r++;
				end
				push_staged();
			end
			wait_drained();
		end
		if (expected_left() == 0 && pushes_left() == 0) begin
			$display("All tests passed");
			$finish;
		end else begin
			stop_with_failure("flits were still owed when the table ran out");
		end
	end

endmodule

//--- sources.f
+incdir+src
+incdir+test
src/noc_pkg.sv
src/input_buffer.sv
src/output_arbiter.sv
src/crossbar.sv
src/mesh_router.sv
test/mesh_router_tb.sv

//--- Makefile
# Verilator build and run of the mesh router testbench

VERILATOR ?= verilator
TOP       ?= mesh_router_tb
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary -j 0
PASS_MSG  ?= All tests passed

SIM_BIN := $(BUILD_DIR)/V$(TOP)
SOURCES := $(wildcard src/*.sv src/*.svh test/*.sv test/*.svh)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, pass only if the pass line is printed"
	@echo "  clean  remove the build directory"
	@echo "  help   list these targets"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS PASS_MSG"

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

test: $(SIM_BIN)
	@out="$$(./$(SIM_BIN) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
